/* source/xbar_settings.svh */
// Crossbar build settings
`ifndef XBAR_SETTINGS_SVH
`define XBAR_SETTINGS_SVH

// Number of masters. The arbiter alternation is written for two.
`define XBAR_MASTERS 2

// Number of slave banks, kept a power of two.
`define XBAR_SLAVES 4

// Request address width.
`define XBAR_ADDR_W 8

// Data word width.
`define XBAR_DATA_W 8

// Words in each slave bank.
`define XBAR_BANK_WORDS 8

`endif

/* source/xbar_pkg.sv */
// Crossbar shared types
`include "xbar_settings.svh"

package xbar_pkg;

    localparam int SLAVE_W  = $clog2(`XBAR_SLAVES);      // Slave index bits.
    localparam int OFFSET_W = $clog2(`XBAR_BANK_WORDS);  // Word offset bits.

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } xbar_op_e;

    // Request as issued by a master.
    typedef struct packed {
        logic                    req;
        xbar_op_e                op;
        logic [`XBAR_ADDR_W-1:0] addr;
        logic [`XBAR_DATA_W-1:0] wdata;
    } xbar_cmd_t;

    // Decoded command, aligned with the slave select.
    typedef struct packed {
        xbar_op_e                op;
        logic [OFFSET_W-1:0]     offset;
        logic [`XBAR_DATA_W-1:0] wdata;
    } xbar_slot_t;

    // Response returned to one master.
    typedef struct packed {
        logic                    valid;
        logic                    nack;
        logic [`XBAR_DATA_W-1:0] rdata;
    } xbar_rsp_t;

endpackage

/* source/decoder_crossbar.sv */
// Pipelined address decoder
`timescale 1ns/100ps
`include "xbar_settings.svh"

module decoder_crossbar (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  xbar_pkg::xbar_cmd_t  [`XBAR_MASTERS-1:0]  cmd,
    output logic [`XBAR_MASTERS-1:0][`XBAR_SLAVES-1:0] slave_sel,
    output xbar_pkg::xbar_slot_t [`XBAR_MASTERS-1:0]  slot
);

    localparam int SW = xbar_pkg::SLAVE_W;
    localparam int OW = xbar_pkg::OFFSET_W;

    logic [`XBAR_MASTERS-1:0]                    req_q;     // Stage 1 request bits.
    xbar_pkg::xbar_cmd_t [`XBAR_MASTERS-1:0]     cmd_q;     // Stage 1 payload.
    logic [`XBAR_MASTERS-1:0][`XBAR_ADDR_W-1:0]  addr_sel;  // Address after inversion.
    logic [`XBAR_MASTERS-1:0][`XBAR_SLAVES-1:0]  sel_d;
    xbar_pkg::xbar_slot_t [`XBAR_MASTERS-1:0]    slot_d;
    logic [`XBAR_MASTERS-1:0][`XBAR_SLAVES-1:0]  sel_q;     // Stage 2 select.
    xbar_pkg::xbar_slot_t [`XBAR_MASTERS-1:0]    slot_q;    // Stage 2 slot.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q <= '0;
        end else begin
            for (int m = 0; m < `XBAR_MASTERS; m++) begin
                req_q[m] <= cmd[m].req;
            end
        end
    end

    always_ff @(posedge clk) begin
        cmd_q <= cmd;  // Op, address and data.
    end

    // High addresses are folded back by a bitwise inversion.
    always_comb begin
        for (int m = 0; m < `XBAR_MASTERS; m++) begin
            addr_sel[m] = cmd_q[m].addr[`XBAR_ADDR_W-1] ? ~cmd_q[m].addr : cmd_q[m].addr;
        end
    end

    always_comb begin
        for (int m = 0; m < `XBAR_MASTERS; m++) begin
            sel_d[m] = '0;
            if (req_q[m]) begin
                sel_d[m][addr_sel[m][SW-1:0]] = 1'b1;  // Modulo as a bit slice.
            end
            slot_d[m].op     = cmd_q[m].op;
            slot_d[m].offset = addr_sel[m][SW +: OW];  // Word offset above slave bits.
            slot_d[m].wdata  = cmd_q[m].wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_q     <= '0;
            slave_sel <= '0;
        end else begin
            sel_q     <= sel_d;
            slave_sel <= sel_q;  // Stage 3 output.
        end
    end

    always_ff @(posedge clk) begin
        slot_q <= slot_d;
        slot   <= slot_q;  // Kept aligned with slave_sel.
    end

endmodule

/* source/slave_arbiter.sv */
// Per-slave round-robin arbiter
`timescale 1ns/100ps
`include "xbar_settings.svh"

module slave_arbiter (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic [`XBAR_MASTERS-1:0]                 sel,
    input  xbar_pkg::xbar_slot_t [`XBAR_MASTERS-1:0] slots,
    output logic [`XBAR_MASTERS-1:0]                 grant,
    output logic                                     rd
);

    logic                     ptr;        // Master favoured on the next conflict.
    logic                     contested;
    logic [`XBAR_MASTERS-1:0] reading;    // Masters whose slot is a read.

    assign contested = &sel;

    // A lone requester always wins.
    always_comb begin
        if (contested) begin
            grant      = '0;
            grant[ptr] = 1'b1;
        end else begin
            grant = sel;
        end
    end

    always_comb begin
        for (int m = 0; m < `XBAR_MASTERS; m++) begin
            reading[m] = (slots[m].op == xbar_pkg::OP_READ);
        end
    end

    assign rd = |(grant & reading);  // Read strobe for the bank.

    // Pointer moves on contested grants only.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= 1'b0;
        end else if (contested) begin
            ptr <= ~ptr;
        end
    end

endmodule

/* source/slave_bank.sv */
// Slave register bank
`timescale 1ns/100ps
`include "xbar_settings.svh"

module slave_bank (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          we,
    input  logic                          rd,
    input  logic [xbar_pkg::OFFSET_W-1:0] offset,
    input  logic [`XBAR_DATA_W-1:0]       wdata,
    output logic [`XBAR_DATA_W-1:0]       rdata
);

    logic [`XBAR_DATA_W-1:0] mem [`XBAR_BANK_WORDS];  // Register array.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < `XBAR_BANK_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (we) begin
            mem[offset] <= wdata;
        end
    end

    // Read data holds until the next read.
    always_ff @(posedge clk) begin
        if (rd) begin
            rdata <= mem[offset];
        end
    end

endmodule

/* source/response_router.sv */
// Per-master response router
`timescale 1ns/100ps
`include "xbar_settings.svh"

module response_router (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic [`XBAR_MASTERS-1:0][`XBAR_SLAVES-1:0]  slave_sel,
    input  logic [`XBAR_SLAVES-1:0][`XBAR_MASTERS-1:0]  grant,
    input  logic [`XBAR_SLAVES-1:0][`XBAR_DATA_W-1:0]   bank_rdata,
    output xbar_pkg::xbar_rsp_t [`XBAR_MASTERS-1:0]     rsp
);

    localparam int SW = xbar_pkg::SLAVE_W;

    logic [`XBAR_MASTERS-1:0]         won;      // Master holds a grant somewhere.
    logic [`XBAR_MASTERS-1:0][SW-1:0] won_idx;  // Slave that granted it.
    logic [`XBAR_MASTERS-1:0]         valid_q;
    logic [`XBAR_MASTERS-1:0]         nack_q;
    logic [`XBAR_MASTERS-1:0][SW-1:0] idx_q;

    always_comb begin
        won     = '0;
        won_idx = '0;
        for (int m = 0; m < `XBAR_MASTERS; m++) begin
            for (int s = 0; s < `XBAR_SLAVES; s++) begin
                if (grant[s][m]) begin
                    won[m]     = 1'b1;
                    won_idx[m] = SW'(s);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            nack_q  <= '0;
        end else begin
            for (int m = 0; m < `XBAR_MASTERS; m++) begin
                valid_q[m] <= |slave_sel[m];
                nack_q[m]  <= |slave_sel[m] & ~won[m];  // Lost the arbitration.
            end
        end
    end

    always_ff @(posedge clk) begin
        idx_q <= won_idx;
    end

    // Bank read data is already registered, so the mux stays combinational.
    always_comb begin
        for (int m = 0; m < `XBAR_MASTERS; m++) begin
            rsp[m].valid = valid_q[m];
            rsp[m].nack  = nack_q[m];
            rsp[m].rdata = bank_rdata[idx_q[m]];
        end
    end

endmodule

/* source/xbar_top.sv */
// Register-access crossbar top
`timescale 1ns/100ps
`include "xbar_settings.svh"

module xbar_top (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  xbar_pkg::xbar_cmd_t [`XBAR_MASTERS-1:0] cmd,
    output xbar_pkg::xbar_rsp_t [`XBAR_MASTERS-1:0] rsp
);

    logic [`XBAR_MASTERS-1:0][`XBAR_SLAVES-1:0] slave_sel;
    xbar_pkg::xbar_slot_t [`XBAR_MASTERS-1:0]   slot;
    logic [`XBAR_SLAVES-1:0][`XBAR_MASTERS-1:0] grant;
    logic [`XBAR_SLAVES-1:0][`XBAR_DATA_W-1:0]  bank_rdata;

    decoder_crossbar u_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .slave_sel (slave_sel),
        .slot      (slot)
    );

    for (genvar s = 0; s < `XBAR_SLAVES; s++) begin : g_slave
        logic [`XBAR_MASTERS-1:0] col;     // Masters selecting this slave.
        xbar_pkg::xbar_slot_t     picked;  // Granted master's slot.
        logic                     rd;
        logic                     we;

        for (genvar m = 0; m < `XBAR_MASTERS; m++) begin : g_col
            assign col[m] = slave_sel[m][s];
        end

        always_comb begin
            picked = '0;
            for (int m = 0; m < `XBAR_MASTERS; m++) begin
                if (grant[s][m]) begin
                    picked = slot[m];
                end
            end
        end

        assign we = |grant[s] && (picked.op == xbar_pkg::OP_WRITE);

        slave_arbiter u_arb (
            .clk   (clk),
            .rst_n (rst_n),
            .sel   (col),
            .slots (slot),
            .grant (grant[s]),
            .rd    (rd)
        );

        slave_bank u_bank (
            .clk    (clk),
            .rst_n  (rst_n),
            .we     (we),
            .rd     (rd),
            .offset (picked.offset),
            .wdata  (picked.wdata),
            .rdata  (bank_rdata[s])
        );
    end

    response_router u_router (
        .clk        (clk),
        .rst_n      (rst_n),
        .slave_sel  (slave_sel),
        .grant      (grant),
        .bank_rdata (bank_rdata),
        .rsp        (rsp)
    );

endmodule

/* verification/xbar_asserts.sv */
// Crossbar grant and response checks
`timescale 1ns/100ps
`include "xbar_settings.svh"

module xbar_asserts (
    input logic                                       clk,
    input logic                                       rst_n,
    input xbar_pkg::xbar_cmd_t [`XBAR_MASTERS-1:0]    cmd,
    input logic [`XBAR_SLAVES-1:0][`XBAR_MASTERS-1:0] grant,
    input xbar_pkg::xbar_rsp_t [`XBAR_MASTERS-1:0]    rsp
);

    for (genvar s = 0; s < `XBAR_SLAVES; s++) begin : g_slave
        // A slave serves one master per cycle.
        grant_onehot: assert property (
            @(posedge clk) disable iff (!rst_n) $onehot0(grant[s])
        ) else $error("Slave %0d granted more than one master", s);
    end

    for (genvar m = 0; m < `XBAR_MASTERS; m++) begin : g_master
        // A loser is nacked in the same cycle in which the winner is served.
        nack_with_valid: assert property (
            @(posedge clk) disable iff (!rst_n)
                rsp[m].nack |-> rsp[m].valid && rsp[1-m].valid && !rsp[1-m].nack
        ) else $error("Master %0d nack raised without valid or without a served winner", m);

        // Valid is registered at the third edge and sampled at the fourth.
        req_gets_rsp: assert property (
            @(posedge clk) disable iff (!rst_n) cmd[m].req |-> ##4 rsp[m].valid
        ) else $error("Master %0d request got no response", m);
    end

endmodule

bind xbar_top xbar_asserts u_asserts (
    .clk   (clk),
    .rst_n (rst_n),
    .cmd   (cmd),
    .grant (grant),
    .rsp   (rsp)
);

/* verification/xbar_tb.sv */
// Crossbar directed testbench
`timescale 1ns/100ps
`include "xbar_settings.svh"

module xbar_tb;

    localparam int M          = `XBAR_MASTERS;
    localparam int CLK_PERIOD = 100;
    localparam int STREAM_LEN = 200;

    // Cycle budget of each test, used by the watchdog.
    localparam int RESET_LEN    = 3;
    localparam int IDLE_LEN     = 6 + 32 + 4;
    localparam int MAP_LEN      = 8 + 4 + 8 + 4 + 4 + 4;
    localparam int TIMING_LEN   = 10;
    localparam int CONFLICT_LEN = 20;
    localparam int PARALLEL_LEN = 12;
    localparam int WATCHDOG_CYCLES = RESET_LEN + IDLE_LEN + MAP_LEN + TIMING_LEN +
                                     CONFLICT_LEN + PARALLEL_LEN + STREAM_LEN + 4 + 50;

    localparam xbar_pkg::xbar_cmd_t NO_CMD = '0;

    // Expected response of both masters for one request cycle.
    typedef struct packed {
        xbar_pkg::xbar_rsp_t [M-1:0] rsp;
        logic [M-1:0]                chk_rdata;  // Read data is meaningful.
    } exp_t;

    logic                                clk = 1'b0;
    logic                                rst_n;
    xbar_pkg::xbar_cmd_t [M-1:0]         cmd;
    xbar_pkg::xbar_rsp_t [M-1:0]         rsp;

    logic [`XBAR_DATA_W-1:0] mem_model [`XBAR_SLAVES][`XBAR_BANK_WORDS];
    int                      ptr_model [`XBAR_SLAVES];  // Master favoured on a conflict.
    exp_t                    exp_q [$];                 // One entry per driven cycle.
    integer                  seed;
    int                      error_count;
    int                      tests_run;

    xbar_top uut (
        .clk   (clk),
        .rst_n (rst_n),
        .cmd   (cmd),
        .rsp   (rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // High addresses map back onto the low half by inversion.
    function automatic logic [`XBAR_ADDR_W-1:0] fold_addr(input logic [`XBAR_ADDR_W-1:0] addr);
        return addr[`XBAR_ADDR_W-1] ? ~addr : addr;
    endfunction

    function automatic int slave_of(input logic [`XBAR_ADDR_W-1:0] addr);
        return int'(fold_addr(addr)) % `XBAR_SLAVES;
    endfunction

    function automatic int offset_of(input logic [`XBAR_ADDR_W-1:0] addr);
        return (int'(fold_addr(addr)) / `XBAR_SLAVES) % `XBAR_BANK_WORDS;
    endfunction

    function automatic logic [`XBAR_ADDR_W-1:0] addr_for(input int s, input int o);
        return `XBAR_ADDR_W'(o * `XBAR_SLAVES + s);
    endfunction

    function automatic xbar_pkg::xbar_cmd_t build_cmd(input xbar_pkg::xbar_op_e op,
                                                      input logic [`XBAR_ADDR_W-1:0] addr,
                                                      input logic [`XBAR_DATA_W-1:0] data);
        xbar_pkg::xbar_cmd_t c;
        c.req   = 1'b1;
        c.op    = op;
        c.addr  = addr;
        c.wdata = data;
        return c;
    endfunction

    // Reference model step for one request cycle.
    task automatic predict(input xbar_pkg::xbar_cmd_t c0, input xbar_pkg::xbar_cmd_t c1,
                           output exp_t e);
        xbar_pkg::xbar_cmd_t c [M];
        int                  s [M];
        int                  o [M];
        int                  win;
        int                  m;
        logic                clash;
        c[0] = c0;
        c[1] = c1;
        e    = '0;
        for (m = 0; m < M; m++) begin
            s[m] = slave_of(c[m].addr);
            o[m] = offset_of(c[m].addr);
        end
        clash = c[0].req && c[1].req && (s[0] == s[1]);
        win   = -1;
        if (clash) begin
            win = ptr_model[s[0]];
            ptr_model[s[0]] = 1 - ptr_model[s[0]];  // Flips on contested grants only.
        end
        for (m = 0; m < M; m++) begin
            if (c[m].req) begin
                e.rsp[m].valid = 1'b1;
                if (clash && m != win) begin
                    e.rsp[m].nack = 1'b1;
                end else if (c[m].op == xbar_pkg::OP_WRITE) begin
                    mem_model[s[m]][o[m]] = c[m].wdata;
                end else begin
                    e.rsp[m].rdata = mem_model[s[m]][o[m]];
                    e.chk_rdata[m] = 1'b1;
                end
            end
        end
    endtask

    task automatic compare_rsp(input exp_t e);
        xbar_pkg::xbar_rsp_t got;
        xbar_pkg::xbar_rsp_t want;
        int                  m;
        for (m = 0; m < M; m++) begin
            got  = rsp[m];
            want = e.rsp[m];
            if (want.valid && got.valid !== 1'b1) begin
                $display("Missing response on master %0d at time %0t", m, $time);
                error_count++;
            end else if (!want.valid && got.valid !== 1'b0) begin
                $display("Unexpected response on master %0d at time %0t", m, $time);
                error_count++;
            end else if (want.valid) begin
                if (got.nack !== want.nack) begin
                    $display("Mismatch at %0t: master %0d nack %b, expected %b",
                             $time, m, got.nack, want.nack);
                    error_count++;
                end else if (e.chk_rdata[m] && got.rdata !== want.rdata) begin
                    $display("Mismatch at %0t: master %0d rdata %h, expected %h",
                             $time, m, got.rdata, want.rdata);
                    error_count++;
                end
            end
        end
    endtask

    // Entered and left on a falling edge; checks the cycle issued four calls back.
    task automatic run_cycle(input xbar_pkg::xbar_cmd_t c0, input xbar_pkg::xbar_cmd_t c1);
        exp_t due;
        exp_t next;
        if (exp_q.size() >= 4) begin
            due = exp_q.pop_front();
            compare_rsp(due);
        end
        cmd[0] = c0;
        cmd[1] = c1;
        predict(c0, c1, next);
        exp_q.push_back(next);
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic flush_pipeline();
        repeat (4) run_cycle(NO_CMD, NO_CMD);
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests_run++;
        $display("%s: %s (%0d errors)", name,
                 (error_count == start_errors) ? "passed" : "failed",
                 error_count - start_errors);
    endtask

    task automatic test_reset_idle();
        int start_errors;
        int s;
        int o;
        start_errors = error_count;
        repeat (6) run_cycle(NO_CMD, NO_CMD);  // Valid must stay low.
        for (s = 0; s < `XBAR_SLAVES; s++) begin
            for (o = 0; o < `XBAR_BANK_WORDS; o++) begin
                run_cycle(build_cmd(xbar_pkg::OP_READ, addr_for(s, o), '0), NO_CMD);
            end
        end
        flush_pipeline();
        report_test("reset_idle", start_errors);
    endtask

    task automatic test_write_read();
        int                      start_errors;
        int                      i;
        logic [`XBAR_ADDR_W-1:0] addrs [8] = '{8'h00, 8'h05, 8'h0A, 8'h0F,
                                              8'hE3, 8'h9A, 8'hB4, 8'h7D};
        start_errors = error_count;
        for (i = 0; i < 8; i++) begin
            run_cycle(build_cmd(xbar_pkg::OP_WRITE, addrs[i], addrs[i] ^ 8'h5A), NO_CMD);
        end
        flush_pipeline();
        for (i = 0; i < 8; i++) begin
            run_cycle(NO_CMD, build_cmd(xbar_pkg::OP_READ, addrs[i], '0));
        end
        flush_pipeline();
        // 0x01 and 0xFE land on the same slave and word.
        run_cycle(build_cmd(xbar_pkg::OP_WRITE, 8'h01, 8'hC3), NO_CMD);
        run_cycle(NO_CMD, build_cmd(xbar_pkg::OP_READ, 8'hFE, '0));
        run_cycle(NO_CMD, build_cmd(xbar_pkg::OP_WRITE, 8'hFE, 8'h3C));
        run_cycle(build_cmd(xbar_pkg::OP_READ, 8'h01, '0), NO_CMD);
        flush_pipeline();
        report_test("write_read", start_errors);
    endtask

    task automatic test_timing();
        int start_errors;
        int k;
        start_errors = error_count;
        run_cycle(NO_CMD, build_cmd(xbar_pkg::OP_READ, 8'h02, '0));
        for (k = 1; k <= 4; k++) begin
            run_cycle(NO_CMD, NO_CMD);
            if (rsp[1].valid !== (k == 3)) begin
                $display("Mismatch at %0t: master 1 valid %b, %0d cycles after request",
                         $time, rsp[1].valid, k);
                error_count++;
            end
        end
        run_cycle(build_cmd(xbar_pkg::OP_WRITE, 8'h8C, 8'h77), NO_CMD);
        for (k = 1; k <= 4; k++) begin
            run_cycle(NO_CMD, NO_CMD);
            if (rsp[0].valid !== (k == 3)) begin
                $display("Mismatch at %0t: master 0 valid %b, %0d cycles after request",
                         $time, rsp[0].valid, k);
                error_count++;
            end
        end
        report_test("timing", start_errors);
    endtask

    task automatic test_conflict();
        int start_errors;
        int k;
        start_errors = error_count;
        run_cycle(build_cmd(xbar_pkg::OP_WRITE, 8'h06, 8'h11),
                  build_cmd(xbar_pkg::OP_WRITE, 8'h06, 8'h22));
        repeat (3) run_cycle(NO_CMD, NO_CMD);
        if (rsp[0].nack !== 1'b0 || rsp[1].nack !== 1'b1) begin
            $display("Mismatch at %0t: first conflict did not go to master 0", $time);
            error_count++;
        end
        run_cycle(build_cmd(xbar_pkg::OP_WRITE, 8'h06, 8'h33),
                  build_cmd(xbar_pkg::OP_WRITE, 8'h06, 8'h44));
        repeat (3) run_cycle(NO_CMD, NO_CMD);
        if (rsp[0].nack !== 1'b1 || rsp[1].nack !== 1'b0) begin
            $display("Mismatch at %0t: second conflict did not go to master 1", $time);
            error_count++;
        end
        run_cycle(build_cmd(xbar_pkg::OP_READ, 8'h06, '0), NO_CMD);
        repeat (3) run_cycle(NO_CMD, NO_CMD);
        if (rsp[0].rdata !== 8'h44) begin
            $display("Mismatch at %0t: read back %h, expected winner data 44",
                     $time, rsp[0].rdata);
            error_count++;
        end
        for (k = 0; k < 4; k++) begin
            run_cycle(build_cmd(xbar_pkg::OP_READ, 8'h06, '0),
                      build_cmd(xbar_pkg::OP_READ, 8'hF9, '0));  // Alias of 0x06.
        end
        flush_pipeline();
        report_test("conflict", start_errors);
    endtask

    task automatic test_parallel();
        int start_errors;
        int i;
        start_errors = error_count;
        for (i = 0; i < `XBAR_SLAVES; i++) begin
            run_cycle(build_cmd(xbar_pkg::OP_WRITE, addr_for(i, 5), 8'(8'hA0 + i)),
                      build_cmd(xbar_pkg::OP_WRITE, addr_for((i + 1) % 4, 6), 8'(8'hB0 + i)));
        end
        for (i = 0; i < `XBAR_SLAVES; i++) begin
            run_cycle(build_cmd(xbar_pkg::OP_READ, addr_for((i + 1) % 4, 6), '0),
                      build_cmd(xbar_pkg::OP_READ, addr_for(i, 5), '0));
        end
        flush_pipeline();
        report_test("parallel", start_errors);
    endtask

    task automatic test_stream();
        int          start_errors;
        int          i;
        logic [31:0] r0;
        logic [31:0] r1;
        start_errors = error_count;
        for (i = 0; i < STREAM_LEN; i++) begin
            r0 = $random(seed);
            r1 = $random(seed);
            run_cycle(build_cmd(xbar_pkg::xbar_op_e'(r0[0]), r0[15:8], r0[23:16]),
                      build_cmd(xbar_pkg::xbar_op_e'(r1[0]), r1[15:8], r1[23:16]));
        end
        flush_pipeline();
        report_test("stream", start_errors);
    endtask

    task automatic clear_model();
        int s;
        int o;
        for (s = 0; s < `XBAR_SLAVES; s++) begin
            ptr_model[s] = 0;
            for (o = 0; o < `XBAR_BANK_WORDS; o++) begin
                mem_model[s][o] = '0;
            end
        end
    endtask

    initial begin
        seed        = 18;
        error_count = 0;
        tests_run   = 0;
        rst_n       = 1'b0;
        cmd         = '0;
        clear_model();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (4) exp_q.push_back(exp_t'('0));  // Pipeline is empty after reset.
        test_reset_idle();
        test_write_read();
        test_timing();
        test_conflict();
        test_parallel();
        test_stream();
        $display("Tests run: %0d, errors: %0d", tests_run, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired: run still going after %0d clock cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* list.f */
+incdir+source
source/xbar_pkg.sv
source/decoder_crossbar.sv
source/slave_arbiter.sv
source/slave_bank.sv
source/response_router.sv
source/xbar_top.sv
verification/xbar_asserts.sv
verification/xbar_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module xbar_tb -f list.f -Mdir obj_dir -o xbar_sim
	./obj_dir/xbar_sim | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "Simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
